// ==== design/sub_bus_defs.svh ====
`ifndef SUB_BUS_DEFS_SVH
`define SUB_BUS_DEFS_SVH

// region ports behind the arbiter: rom, ram, road, sio
`define SUB_NPORTS 4

// queue depth in each region port, also the arbiter credit count
`define SUB_CREDITS 2

// outstanding transactions tracked for in-order return
`define SUB_ORDER_DEPTH 4

// 68000 style data bus
`define SUB_DATA_W 16

`endif

// ==== design/sub_bus_pkg.sv ====
`include "sub_bus_defs.svh"

package sub_bus_pkg;

    // word address split as the sub CPU memory map sees it
    typedef struct packed {
        logic [2:0]  region;    // A[19:17]
        logic [15:0] offset;    // A[16:1], top bit picks road or sio
    } bus_addr_fields_t;

    typedef union packed {
        logic [18:0]      word; // raw word address
        bus_addr_fields_t f;
    } bus_addr_u;

    typedef enum logic {
        MASTER_SUB  = 1'b0,
        MASTER_MAIN = 1'b1
    } master_e;

    typedef struct packed {
        bus_addr_u              addr;
        logic                   we;
        logic [1:0]             dsn;    // {UDSn, LDSn}
        logic [`SUB_DATA_W-1:0] wdata;
        master_e                master;
    } bus_req_t;

    typedef struct packed {
        logic [`SUB_DATA_W-1:0] data;
    } bus_rsp_t;

endpackage

// ==== design/sub_map_pkg.sv ====
package sub_map_pkg;

    // one value per region port, used as the port index
    typedef enum logic [1:0] {
        REG_ROM  = 2'd0,
        REG_RAM  = 2'd1,
        REG_ROAD = 2'd2,
        REG_SIO  = 2'd3
    } region_e;

    typedef struct packed {
        region_e region;
        logic    unmapped;  // no port takes it, answer is all ones
    } decode_t;

    // address seen by an external memory
    // rom spans three region codes so it keeps two extra bits
    typedef logic [17:0] port_addr_t;

endpackage

// ==== design/sub_bus_if.sv ====
`include "sub_bus_defs.svh"

interface port_req_if;
    import sub_map_pkg::*;

    logic                   valid;
    port_addr_t             offset;
    logic                   we;
    logic [1:0]             dsn;
    logic [`SUB_DATA_W-1:0] wdata;
    logic                   credit_return;  // one queue entry freed

    modport arb  (output valid, offset, we, dsn, wdata, input  credit_return);
    modport port (input  valid, offset, we, dsn, wdata, output credit_return);
endinterface

interface port_rsp_if;
    import sub_bus_pkg::*;

    logic     rsp_valid;    // oldest completed entry waiting
    bus_rsp_t rsp_data;
    logic     pop;

    modport port (output rsp_valid, rsp_data, input  pop);
    modport ret  (input  rsp_valid, rsp_data, output pop);
endinterface

interface order_if;
    import sub_bus_pkg::*;
    import sub_map_pkg::*;

    logic    push;
    region_e region;
    master_e master;
    logic    unmapped;
    logic    full;

    modport arb (output push, region, master, unmapped, input  full);
    modport ret (input  push, region, master, unmapped, output full);
endinterface

// ==== design/bus_arbiter.sv ====
`include "sub_bus_defs.svh"

module bus_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sub_valid,
    input  sub_bus_pkg::bus_req_t sub_req,
    output logic                  sub_ready,
    input  logic                  main_br,
    input  logic                  main_valid,
    input  sub_bus_pkg::bus_req_t main_req,
    output logic                  main_ready,
    port_req_if.arb               preq [`SUB_NPORTS],
    order_if.arb                  ord
);
    import sub_bus_pkg::*;
    import sub_map_pkg::*;

    localparam int CW = $clog2(`SUB_CREDITS + 1);

    bus_req_t              cur_req;
    logic                  cur_valid;
    logic                  can_issue;
    logic                  fire;
    logic                  running;
    decode_t               dec;
    port_addr_t            port_addr;
    logic [CW-1:0]         credits [`SUB_NPORTS];
    logic [`SUB_NPORTS-1:0] have_credit;
    logic [`SUB_NPORTS-1:0] issue;
    logic [`SUB_NPORTS-1:0] ret;

    // main CPU owns the bus while it holds BR
    assign cur_valid = main_br ? main_valid : sub_valid;
    assign cur_req   = main_br ? main_req : sub_req;

    always_comb begin
        dec.unmapped = (cur_req.addr.f.region > 3'd4) || (cur_req.dsn == 2'b11);
        case (cur_req.addr.f.region)
            3'd0, 3'd1, 3'd2: dec.region = REG_ROM;
            3'd3:             dec.region = REG_RAM;
            3'd4:             dec.region = cur_req.addr.f.offset[15] ? REG_SIO : REG_ROAD;
            default:          dec.region = REG_ROM;   // 5-7 flagged unmapped
        endcase
    end

    // rom keeps A[18:17] of the raw word, the rest only see the offset
    assign port_addr = (dec.region == REG_ROM) ? cur_req.addr.word[17:0]
                                               : {2'b00, cur_req.addr.f.offset};

    assign can_issue  = running && !ord.full && (dec.unmapped || have_credit[dec.region]);
    assign fire       = cur_valid && can_issue;
    assign sub_ready  = !main_br && can_issue;
    assign main_ready = main_br && can_issue;

    assign ord.push     = fire;
    assign ord.region   = dec.region;
    assign ord.master   = cur_req.master;
    assign ord.unmapped = dec.unmapped;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;    // hold ready low for the first cycle
        end
    end

    for (genvar i = 0; i < `SUB_NPORTS; i++) begin : g_port
        assign issue[i]       = fire && !dec.unmapped && (dec.region == region_e'(i));
        assign have_credit[i] = credits[i] != '0;
        assign ret[i]         = preq[i].credit_return;

        assign preq[i].valid  = issue[i];
        assign preq[i].offset = port_addr;
        assign preq[i].we     = cur_req.we;
        assign preq[i].dsn    = cur_req.dsn;
        assign preq[i].wdata  = cur_req.wdata;

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                credits[i] <= CW'(`SUB_CREDITS);
            end else begin
                credits[i] <= credits[i] - CW'(issue[i]) + CW'(ret[i]);
            end
        end

        // counter stays within the port queue depth
        a_credit_range: assert property (@(posedge clk) disable iff (rst)
            credits[i] <= CW'(`SUB_CREDITS));
    end

endmodule

// ==== design/region_port.sv ====
`include "sub_bus_defs.svh"

module region_port (
    input  logic                    clk,
    input  logic                    rst,
    port_req_if.port                preq,
    port_rsp_if.port                prsp,
    output logic                    mem_cs,
    output sub_map_pkg::port_addr_t mem_addr,
    output logic                    mem_we,
    output logic [1:0]              mem_dsn,
    output logic [`SUB_DATA_W-1:0]  mem_wdata,
    input  logic                    mem_ok,
    input  logic [`SUB_DATA_W-1:0]  mem_rdata
);
    import sub_map_pkg::*;

    localparam int DEPTH = `SUB_CREDITS;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_DONE} state_e;

    port_addr_t             q_addr  [DEPTH];
    logic                   q_we    [DEPTH];
    logic [1:0]             q_dsn   [DEPTH];
    logic [`SUB_DATA_W-1:0] q_wdata [DEPTH];
    logic [PW-1:0]          wr_ptr;
    logic [PW-1:0]          rd_ptr;
    logic [CW-1:0]          count;
    state_e                 state;
    logic [`SUB_DATA_W-1:0] rdata_q;
    logic                   release_entry;

    assign release_entry      = prsp.pop && (state == ST_DONE);
    assign preq.credit_return = release_entry;
    assign prsp.rsp_valid     = state == ST_DONE;
    assign prsp.rsp_data.data = rdata_q;

    // head entry drives the memory for the whole access
    assign mem_addr  = q_addr[rd_ptr];
    assign mem_we    = q_we[rd_ptr];
    assign mem_dsn   = q_dsn[rd_ptr];
    assign mem_wdata = q_wdata[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ST_IDLE;
            mem_cs <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (preq.valid) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (release_entry) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(preq.valid) - CW'(release_entry);
            case (state)
                ST_IDLE: if (count != '0) begin
                    mem_cs <= 1'b1;     // cs the cycle after reaching head
                    state  <= ST_ACCESS;
                end
                ST_ACCESS: if (mem_ok) begin
                    mem_cs <= 1'b0;
                    state  <= ST_DONE;
                end
                ST_DONE: if (release_entry) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (preq.valid) begin
            q_addr[wr_ptr]  <= preq.offset;
            q_we[wr_ptr]    <= preq.we;
            q_dsn[wr_ptr]   <= preq.dsn;
            q_wdata[wr_ptr] <= preq.wdata;
        end
        if (state == ST_ACCESS && mem_ok) rdata_q <= mem_rdata;   // writes capture too
    end

    // the head entry must not change under an open access
    a_cs_until_ok: assert property (@(posedge clk) disable iff (rst)
        mem_cs && !mem_ok |=> mem_cs && $stable(mem_addr) && $stable(mem_wdata));

    // arbiter credits must keep the queue from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        preq.valid |-> count != CW'(DEPTH));

endmodule

// ==== design/bus_return.sv ====
`include "sub_bus_defs.svh"

module bus_return (
    input  logic                  clk,
    input  logic                  rst,
    order_if.ret                  ord,
    port_rsp_if.ret               prsp [`SUB_NPORTS],
    output logic                  sub_rsp_valid,
    output sub_bus_pkg::bus_rsp_t sub_rsp_data,
    output logic                  main_rsp_valid,
    output sub_bus_pkg::bus_rsp_t main_rsp_data,
    input  logic [2:0]            st_addr,
    output logic [7:0]            st_dout
);
    import sub_bus_pkg::*;
    import sub_map_pkg::*;

    localparam int DEPTH = `SUB_ORDER_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    region_e                q_region   [DEPTH];
    master_e                q_master   [DEPTH];
    logic                   q_unmapped [DEPTH];
    logic [7:0]             q_stamp    [DEPTH];
    logic [PW-1:0]          wr_ptr;
    logic [PW-1:0]          rd_ptr;
    logic [CW-1:0]          count;
    logic [7:0]             timer;
    logic [7:0]             worst;
    logic [7:0]             wait_now;
    logic [7:0]             region_cnt [`SUB_NPORTS];
    logic [`SUB_NPORTS-1:0] rsp_valid_v;
    bus_rsp_t               rsp_data_v [`SUB_NPORTS];
    logic                   head_valid;
    logic                   take;
    region_e                head_region;
    master_e                head_master;
    logic                   head_unmapped;
    bus_rsp_t               head_data;

    assign ord.full      = count == CW'(DEPTH);
    assign head_valid    = count != '0;
    assign head_region   = q_region[rd_ptr];
    assign head_master   = q_master[rd_ptr];
    assign head_unmapped = q_unmapped[rd_ptr];
    assign wait_now      = timer - q_stamp[rd_ptr];

    // unmapped heads go at once, mapped ones wait for their port
    assign take = head_valid && (head_unmapped || rsp_valid_v[head_region]);

    always_comb begin
        head_data.data = head_unmapped ? 16'hffff : rsp_data_v[head_region].data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            timer          <= '0;
            worst          <= '0;
            sub_rsp_valid  <= 1'b0;
            main_rsp_valid <= 1'b0;
        end else begin
            timer <= timer + 8'd1;
            if (ord.push) wr_ptr <= wr_ptr + 1'b1;
            if (take) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (wait_now > worst) worst <= wait_now;
            end
            count          <= count + CW'(ord.push) - CW'(take);
            sub_rsp_valid  <= take && (head_master == MASTER_SUB);
            main_rsp_valid <= take && (head_master == MASTER_MAIN);
        end
    end

    always_ff @(posedge clk) begin
        if (ord.push) begin
            q_region[wr_ptr]   <= ord.region;
            q_master[wr_ptr]   <= ord.master;
            q_unmapped[wr_ptr] <= ord.unmapped;
            q_stamp[wr_ptr]    <= timer;
        end
        if (take && head_master == MASTER_SUB)  sub_rsp_data  <= head_data;
        if (take && head_master == MASTER_MAIN) main_rsp_data <= head_data;
    end

    for (genvar i = 0; i < `SUB_NPORTS; i++) begin : g_port
        assign rsp_valid_v[i] = prsp[i].rsp_valid;
        assign rsp_data_v[i]  = prsp[i].rsp_data;
        assign prsp[i].pop    = take && !head_unmapped && (head_region == region_e'(i));

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                region_cnt[i] <= '0;
            end else if (prsp[i].pop) begin
                region_cnt[i] <= region_cnt[i] + 8'd1;  // wraps at 255
            end
        end

        // a port only completes work that still has an order entry
        a_rsp_has_order: assert property (@(posedge clk) disable iff (rst)
            rsp_valid_v[i] |-> head_valid);
    end

    always_comb begin
        case (st_addr)
            3'd0, 3'd1, 3'd2, 3'd3: st_dout = region_cnt[st_addr[1:0]];
            3'd4:                   st_dout = worst;
            default:                st_dout = 8'd0;
        endcase
    end

    a_push_not_full: assert property (@(posedge clk) disable iff (rst)
        ord.push |-> !ord.full);

endmodule

// ==== design/sub_bus_top.sv ====
`include "sub_bus_defs.svh"

module sub_bus_top (
    input  logic                                        clk,
    input  logic                                        rst,
    // sub CPU
    input  logic                                        sub_valid,
    output logic                                        sub_ready,
    input  logic [18:0]                                 sub_addr,
    input  logic                                        sub_we,
    input  logic [1:0]                                  sub_dsn,
    input  logic [`SUB_DATA_W-1:0]                      sub_wdata,
    output logic                                        sub_rsp_valid,
    output logic [`SUB_DATA_W-1:0]                      sub_rsp_data,
    // main CPU, owns the bus while main_br is high
    input  logic                                        main_br,
    input  logic                                        main_valid,
    output logic                                        main_ready,
    input  logic [18:0]                                 main_addr,
    input  logic                                        main_we,
    input  logic [1:0]                                  main_dsn,
    input  logic [`SUB_DATA_W-1:0]                      main_wdata,
    output logic                                        main_rsp_valid,
    output logic [`SUB_DATA_W-1:0]                      main_rsp_data,
    // external memories, indexed by region
    output logic [`SUB_NPORTS-1:0]                      mem_cs,
    output sub_map_pkg::port_addr_t [`SUB_NPORTS-1:0]   mem_addr,
    output logic [`SUB_NPORTS-1:0]                      mem_we,
    output logic [`SUB_NPORTS-1:0][1:0]                 mem_dsn,
    output logic [`SUB_NPORTS-1:0][`SUB_DATA_W-1:0]     mem_wdata,
    input  logic [`SUB_NPORTS-1:0]                      mem_ok,
    input  logic [`SUB_NPORTS-1:0][`SUB_DATA_W-1:0]     mem_rdata,
    // status readout
    input  logic [2:0]                                  st_addr,
    output logic [7:0]                                  st_dout
);
    import sub_bus_pkg::*;

    bus_req_t sub_req;
    bus_req_t main_req;
    bus_rsp_t sub_rsp;
    bus_rsp_t main_rsp;

    port_req_if preq [`SUB_NPORTS] ();
    port_rsp_if prsp [`SUB_NPORTS] ();
    order_if    ord ();

    assign sub_req.addr.word  = sub_addr;
    assign sub_req.we         = sub_we;
    assign sub_req.dsn        = sub_dsn;
    assign sub_req.wdata      = sub_wdata;
    assign sub_req.master     = MASTER_SUB;

    assign main_req.addr.word = main_addr;
    assign main_req.we        = main_we;
    assign main_req.dsn       = main_dsn;
    assign main_req.wdata     = main_wdata;
    assign main_req.master    = MASTER_MAIN;

    assign sub_rsp_data  = sub_rsp.data;
    assign main_rsp_data = main_rsp.data;

    bus_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .sub_valid  (sub_valid),
        .sub_req    (sub_req),
        .sub_ready  (sub_ready),
        .main_br    (main_br),
        .main_valid (main_valid),
        .main_req   (main_req),
        .main_ready (main_ready),
        .preq       (preq),
        .ord        (ord)
    );

    for (genvar i = 0; i < `SUB_NPORTS; i++) begin : g_region
        region_port u_port (
            .clk       (clk),
            .rst       (rst),
            .preq      (preq[i]),
            .prsp      (prsp[i]),
            .mem_cs    (mem_cs[i]),
            .mem_addr  (mem_addr[i]),
            .mem_we    (mem_we[i]),
            .mem_dsn   (mem_dsn[i]),
            .mem_wdata (mem_wdata[i]),
            .mem_ok    (mem_ok[i]),
            .mem_rdata (mem_rdata[i])
        );
    end

    bus_return u_return (
        .clk            (clk),
        .rst            (rst),
        .ord            (ord),
        .prsp           (prsp),
        .sub_rsp_valid  (sub_rsp_valid),
        .sub_rsp_data   (sub_rsp),
        .main_rsp_valid (main_rsp_valid),
        .main_rsp_data  (main_rsp),
        .st_addr        (st_addr),
        .st_dout        (st_dout)
    );

endmodule

// ==== bench/mem_model.sv ====
`include "sub_bus_defs.svh"

module mem_model (
    input  logic                                      clk,
    input  logic [1:0]                                delay_pick,  // wait states for next access
    input  logic [`SUB_NPORTS-1:0]                    mem_cs,
    input  sub_map_pkg::port_addr_t [`SUB_NPORTS-1:0] mem_addr,
    input  logic [`SUB_NPORTS-1:0]                    mem_we,
    input  logic [`SUB_NPORTS-1:0][1:0]               mem_dsn,
    input  logic [`SUB_NPORTS-1:0][`SUB_DATA_W-1:0]   mem_wdata,
    output logic [`SUB_NPORTS-1:0]                    mem_ok,
    output logic [`SUB_NPORTS-1:0][`SUB_DATA_W-1:0]   mem_rdata
);
    import sub_map_pkg::*;

    logic [1:0]             wait_left [`SUB_NPORTS];
    logic [`SUB_DATA_W-1:0] ram_words [port_addr_t];   // only written ram words
    logic [`SUB_DATA_W-1:0] old_word;

    // region index folded with every address bit
    function automatic logic [15:0] fill_word(input int port, input port_addr_t a);
        return a[15:0] ^ {a[17:16], 12'h000, 2'(port)};
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] wd,
                                                input logic [1:0] dsn);
        logic [15:0] res;
        res = old;
        if (!dsn[1]) res[15:8] = wd[15:8];  // UDSn low
        if (!dsn[0]) res[7:0] = wd[7:0];
        return res;
    endfunction

    initial begin
        mem_ok    = '0;
        mem_rdata = '0;
        for (int i = 0; i < `SUB_NPORTS; i++) begin
            wait_left[i] = 2'd0;
        end
    end

    always @(negedge clk) begin
        for (int i = 0; i < `SUB_NPORTS; i++) begin
            if (mem_ok[i]) begin
                mem_ok[i]    <= 1'b0;       // cs has dropped by now
                wait_left[i] <= delay_pick;
            end else if (mem_cs[i]) begin
                if (wait_left[i] != 2'd0) begin
                    wait_left[i] <= wait_left[i] - 2'd1;
                end else begin
                    mem_ok[i] <= 1'b1;
                    old_word = ram_words.exists(mem_addr[i]) ? ram_words[mem_addr[i]]
                                                             : fill_word(i, mem_addr[i]);
                    if (!mem_we[i]) begin
                        mem_rdata[i] <= old_word;
                    end else if (i == int'(REG_RAM)) begin
                        ram_words[mem_addr[i]] = merge_bytes(old_word, mem_wdata[i], mem_dsn[i]);
                    end
                end
            end
        end
    end

endmodule

// ==== bench/tb_sub_bus.sv ====
`include "sub_bus_defs.svh"

module tb_sub_bus;
    import sub_bus_pkg::*;
    import sub_map_pkg::*;

    localparam logic [31:0] SEED    = 32'h51a6_ca9f;
    localparam int          N_TRANS = 33;               // requests issued over all tests
    localparam int          LIMIT   = 40 * N_TRANS + 50;

    logic                                    clk = 1'b0;
    logic                                    rst;
    logic                                    sub_valid;
    logic                                    sub_ready;
    logic [18:0]                             sub_addr;
    logic                                    sub_we;
    logic [1:0]                              sub_dsn;
    logic [`SUB_DATA_W-1:0]                  sub_wdata;
    logic                                    sub_rsp_valid;
    logic [`SUB_DATA_W-1:0]                  sub_rsp_data;
    logic                                    main_br;
    logic                                    main_valid;
    logic                                    main_ready;
    logic [18:0]                             main_addr;
    logic                                    main_we;
    logic [1:0]                              main_dsn;
    logic [`SUB_DATA_W-1:0]                  main_wdata;
    logic                                    main_rsp_valid;
    logic [`SUB_DATA_W-1:0]                  main_rsp_data;
    logic [`SUB_NPORTS-1:0]                  mem_cs;
    port_addr_t [`SUB_NPORTS-1:0]            mem_addr;
    logic [`SUB_NPORTS-1:0]                  mem_we;
    logic [`SUB_NPORTS-1:0][1:0]             mem_dsn;
    logic [`SUB_NPORTS-1:0][`SUB_DATA_W-1:0] mem_wdata;
    logic [`SUB_NPORTS-1:0]                  mem_ok;
    logic [`SUB_NPORTS-1:0][`SUB_DATA_W-1:0] mem_rdata;
    logic [2:0]                              st_addr;
    logic [7:0]                              st_dout;
    logic [1:0]                              delay_pick = 2'd0;

    logic [31:0] rnd_state = SEED;
    logic [31:0] dly_state = SEED;
    int          cycles = 0;
    int          mismatches = 0;
    int          other_errs = 0;
    int          region_seen [`SUB_NPORTS];
    logic [15:0] shadow [port_addr_t];      // ram words written so far
    bus_rsp_t    sub_exp [$];
    bus_rsp_t    main_exp [$];
    bit          sub_care [$];               // writes answer with junk data
    bit          main_care [$];
    int          sub_stamp [$];              // edge on which each request was taken
    int          main_stamp [$];
    int          worst_wait = 0;
    bus_rsp_t    mon_got;
    bus_rsp_t    mon_exp;
    bit          mon_care;

    sub_bus_top u_dut (.*);
    mem_model u_mem (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory map as seen by the sub CPU
    function automatic region_e region_of(input logic [18:0] a);
        if (a[18:16] <= 3'd2) return REG_ROM;
        if (a[18:16] == 3'd3) return REG_RAM;
        return a[15] ? REG_SIO : REG_ROAD;
    endfunction

    function automatic port_addr_t port_addr_of(input logic [18:0] a);
        return (region_of(a) == REG_ROM) ? a[17:0] : {2'b00, a[15:0]};
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] wd,
                                                input logic [1:0] dsn);
        logic [15:0] res;
        res = old;
        if (!dsn[1]) res[15:8] = wd[15:8];
        if (!dsn[0]) res[7:0] = wd[7:0];
        return res;
    endfunction

    function automatic logic [15:0] stored_word(input logic [18:0] a);
        port_addr_t pa;
        pa = port_addr_of(a);
        if (region_of(a) == REG_RAM && shadow.exists(pa)) return shadow[pa];
        return pa[15:0] ^ {pa[17:16], 12'h000, 2'(region_of(a))};
    endfunction

    function automatic bit is_unmapped(input logic [18:0] a, input logic [1:0] dsn);
        return (dsn == 2'b11) || (a[18:16] > 3'd4);
    endfunction

    task automatic check_data(input bus_rsp_t got, input bus_rsp_t exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got.data, exp.data);
        end
    endtask

    task automatic check_status(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // called at a falling edge, returns at the next one
    task automatic send_req(input master_e m, input logic [18:0] a, input logic we,
                            input logic [1:0] dsn, input logic [15:0] wdata);
        bus_rsp_t exp;
        bit       unm;
        unm = is_unmapped(a, dsn);
        exp.data = unm ? 16'hffff : stored_word(a);
        if (m == MASTER_MAIN) begin
            main_valid = 1'b1;
            main_addr  = a;
            main_we    = we;
            main_dsn   = dsn;
            main_wdata = wdata;
        end else begin
            sub_valid = 1'b1;
            sub_addr  = a;
            sub_we    = we;
            sub_dsn   = dsn;
            sub_wdata = wdata;
        end
        #1;
        while (!((m == MASTER_MAIN) ? main_ready : sub_ready)) begin
            @(negedge clk);
            #1;
        end
        // transfer happens at the coming rising edge
        if (!unm) begin
            region_seen[region_of(a)]++;
            if (we && region_of(a) == REG_RAM) begin
                shadow[port_addr_of(a)] = merge_bytes(stored_word(a), wdata, dsn);
            end
        end
        if (m == MASTER_MAIN) begin
            main_exp.push_back(exp);
            main_care.push_back(!we);
            main_stamp.push_back(cycles + 1);
        end else begin
            sub_exp.push_back(exp);
            sub_care.push_back(!we);
            sub_stamp.push_back(cycles + 1);
        end
        @(negedge clk);
        if (m == MASTER_MAIN) begin
            main_valid = 1'b0;
        end else begin
            sub_valid = 1'b0;
        end
    endtask

    task automatic wait_drained;
        while (sub_exp.size() != 0 || main_exp.size() != 0) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
    endtask

    task automatic take_response(input master_e m, input logic [15:0] data);
        int waited;
        if ((m == MASTER_MAIN) ? main_exp.size() == 0 : sub_exp.size() == 0) begin
            other_errs++;
            $display("response on the %s side at %0t with nothing outstanding",
                     (m == MASTER_MAIN) ? "main" : "sub", $time);
        end else begin
            mon_exp  = (m == MASTER_MAIN) ? main_exp.pop_front() : sub_exp.pop_front();
            mon_care = (m == MASTER_MAIN) ? main_care.pop_front() : sub_care.pop_front();
            waited   = cycles - ((m == MASTER_MAIN) ? main_stamp.pop_front()
                                                    : sub_stamp.pop_front());
            if (waited > worst_wait) worst_wait = waited;
            mon_got.data = data;
            if (mon_care) check_data(mon_got, mon_exp, (m == MASTER_MAIN) ? "main read" : "sub read");
        end
    endtask

    task automatic test_region_reads;
        if (sub_ready || main_ready || mem_cs != '0 || sub_rsp_valid || main_rsp_valid) begin
            other_errs++;
            $display("outputs not idle right after reset");
        end
        send_req(MASTER_SUB, {3'd0, 16'h1234}, 1'b0, 2'b00, 16'h0);
        send_req(MASTER_SUB, {3'd2, 16'h5a5a}, 1'b0, 2'b00, 16'h0);   // rom keeps A18..17
        send_req(MASTER_SUB, {3'd3, 16'h0040}, 1'b0, 2'b00, 16'h0);
        send_req(MASTER_SUB, {3'd4, 16'h0123}, 1'b0, 2'b00, 16'h0);
        send_req(MASTER_SUB, {3'd4, 16'h8123}, 1'b0, 2'b00, 16'h0);
        wait_drained();
    endtask

    task automatic test_ram_write_read;
        send_req(MASTER_SUB, {3'd3, 16'h0100}, 1'b1, 2'b00, 16'hbeef);
        send_req(MASTER_SUB, {3'd3, 16'h0100}, 1'b0, 2'b00, 16'h0);
        send_req(MASTER_SUB, {3'd3, 16'h0100}, 1'b1, 2'b10, 16'h1234);  // low byte only
        send_req(MASTER_SUB, {3'd3, 16'h0100}, 1'b0, 2'b00, 16'h0);
        wait_drained();
    endtask

    task automatic test_unmapped;
        send_req(MASTER_SUB, {3'd5, 16'h0010}, 1'b0, 2'b00, 16'h0);
        send_req(MASTER_SUB, {3'd6, 16'h8020}, 1'b0, 2'b00, 16'h0);
        send_req(MASTER_SUB, {3'd7, 16'hffff}, 1'b0, 2'b00, 16'h0);
        send_req(MASTER_SUB, {3'd0, 16'h0300}, 1'b0, 2'b11, 16'h0);
        wait_drained();
    endtask

    task automatic test_burst;
        logic [2:0]  code;
        logic [15:0] offset;
        for (int n = 0; n < 16; n++) begin
            rnd_state = lcg_next(rnd_state);
            code   = 3'(rnd_state[31:24] % 8'd5);
            offset = rnd_state[23:8];
            send_req(MASTER_SUB, {code, offset}, 1'b0, 2'b00, 16'h0);
        end
        wait_drained();
    endtask

    task automatic test_main_owner;
        main_br   = 1'b1;
        sub_valid = 1'b1;   // parked sub request must wait
        sub_addr  = {3'd0, 16'h0777};
        sub_we    = 1'b0;
        sub_dsn   = 2'b00;
        #1;
        if (sub_ready) begin
            other_errs++;
            $display("sub request ready while the main CPU holds the bus");
        end
        @(negedge clk);
        send_req(MASTER_MAIN, {3'd1, 16'h4321}, 1'b0, 2'b00, 16'h0);
        send_req(MASTER_MAIN, {3'd3, 16'h0100}, 1'b0, 2'b00, 16'h0);
        send_req(MASTER_MAIN, {3'd4, 16'hc001}, 1'b0, 2'b00, 16'h0);
        send_req(MASTER_MAIN, {3'd6, 16'h0001}, 1'b0, 2'b00, 16'h0);
        wait_drained();
        sub_valid = 1'b0;
        main_br   = 1'b0;
        @(negedge clk);
    endtask

    task automatic test_status;
        for (int i = 0; i < `SUB_NPORTS; i++) begin
            st_addr = 3'(i);
            #1;
            check_status(st_dout, 8'(region_seen[i]), $sformatf("region %0d count", i));
            @(negedge clk);
        end
        st_addr = 3'd4;
        #1;
        check_status(st_dout, 8'(worst_wait), "worst wait");
        @(negedge clk);
        for (int i = 5; i < 8; i++) begin
            st_addr = 3'(i);
            #1;
            check_status(st_dout, 8'd0, $sformatf("status address %0d", i));
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        dly_state  <= lcg_next(dly_state);
        delay_pick <= dly_state[31:30];
    end

    always @(negedge clk) begin
        if (sub_rsp_valid) take_response(MASTER_SUB, sub_rsp_data);
        if (main_rsp_valid) take_response(MASTER_MAIN, main_rsp_data);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, responses still outstanding", LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        sub_valid  = 1'b0;
        sub_addr   = '0;
        sub_we     = 1'b0;
        sub_dsn    = 2'b00;
        sub_wdata  = '0;
        main_br    = 1'b0;
        main_valid = 1'b0;
        main_addr  = '0;
        main_we    = 1'b0;
        main_dsn   = 2'b00;
        main_wdata = '0;
        st_addr    = 3'd0;
        for (int i = 0; i < `SUB_NPORTS; i++) begin
            region_seen[i] = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_region_reads();
        test_ram_write_read();
        test_unmapped();
        test_burst();
        test_main_owner();
        test_status();
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+design
design/sub_bus_pkg.sv
design/sub_map_pkg.sv
design/sub_bus_if.sv
design/bus_arbiter.sv
design/region_port.sv
design/bus_return.sv
design/sub_bus_top.sv
bench/mem_model.sv
bench/tb_sub_bus.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sub bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_sub_bus -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
